//--- sram_pkg.sv
`default_nettype none

package sram_pkg;

  // chip geometry, 1K x 16 with two byte lanes
  localparam int addr_width = 10;
  localparam int data_width = 16;
  localparam int strb_width = data_width / 8;

  // cycles each access holds the chip strobes low
  localparam int access_cycles = 3;
  localparam int timer_width = (access_cycles > 1) ? $clog2(access_cycles) : 1;

  // read response buffering
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  localparam int fifo_count_width = 3;

  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic                  wr_en;
    logic [data_width-1:0] wr_data;
    logic [strb_width-1:0] wr_strb;
  } sram_cmd_t;

  // next-cycle pin request from the FSM
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [strb_width-1:0] be_n;
    logic                  ce_n;
    logic                  oe_n;
    logic                  we_n;
    logic                  drive;
    logic [data_width-1:0] wr_data;
    logic                  capture;
  } pad_ctrl_t;

  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [strb_width-1:0] be_n;
    logic                  ce_n;
    logic                  oe_n;
    logic                  we_n;
  } sram_pins_t;

endpackage

`default_nettype wire

//--- sram_wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sram_wait_timer import sram_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic busy,
  output logic last
);

  logic [timer_width-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy  <= 1'b1;
      count <= timer_width'(access_cycles - 1);
    end else if (busy) begin
      if (count == '0) begin
        busy <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  // final cycle of the access
  assign last = busy && (count == '0);

endmodule

`default_nettype wire

//--- sram_access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sram_access_fsm import sram_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_valid,
  input  sram_cmd_t                   cmd,
  input  logic                        timer_last,
  input  logic [fifo_count_width-1:0] fill_count,
  output logic                        cmd_ready,
  output logic                        timer_start,
  output pad_ctrl_t                   pad_req
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } state_t;

  state_t    state;
  state_t    state_next;
  sram_cmd_t cur_q;
  sram_cmd_t cur;
  logic      accept;

  // keep one slot free for a read that may still be in flight
  assign cmd_ready = (state == st_idle) &&
                     (fill_count < fifo_count_width'(fifo_depth - 1));
  assign accept = cmd_valid && cmd_ready;
  assign timer_start = accept;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (accept) begin
          state_next = cmd.wr_en ? st_write : st_read;
        end
      end
      st_read, st_write: begin
        if (timer_last) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // hold the command for the rest of the access
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_q <= cmd;
    end
  end

  assign cur = accept ? cmd : cur_q;

  // strobes from the next state, registered in the pad block
  always_comb begin
    pad_req.addr    = cur.addr;
    pad_req.wr_data = cur.wr_data;
    pad_req.be_n    = '1;
    if (state_next != st_idle) begin
      // reads enable both lanes
      pad_req.be_n = cur.wr_en ? ~cur.wr_strb : '0;
    end
    pad_req.ce_n    = (state_next == st_idle);
    pad_req.oe_n    = (state_next != st_read);
    pad_req.we_n    = (state_next != st_write);
    // one extra cycle of drive as data hold
    pad_req.drive   = (state_next == st_write) || (state == st_write);
    pad_req.capture = (state == st_read) && timer_last;
  end

endmodule

`default_nettype wire

//--- sram_pad_io.sv
`timescale 1ns/1ps
`default_nettype none

module sram_pad_io import sram_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pad_ctrl_t             pad_req,
  output sram_pins_t            pins,
  output logic                  rd_strobe,
  output logic [data_width-1:0] rd_data,
  inout  wire  [data_width-1:0] sram_data
);

  logic [addr_width-1:0] addr_q;
  logic [data_width-1:0] wr_data_q;
  logic [strb_width-1:0] be_n_q;
  logic                  ce_n_q;
  logic                  oe_n_q;
  logic                  we_n_q;
  logic                  drive_q;

  always_ff @(posedge clk) begin
    addr_q    <= pad_req.addr;
    wr_data_q <= pad_req.wr_data;
  end

  // chip strobes idle high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      be_n_q  <= '1;
      ce_n_q  <= 1'b1;
      oe_n_q  <= 1'b1;
      we_n_q  <= 1'b1;
      drive_q <= 1'b0;
    end else begin
      be_n_q  <= pad_req.be_n;
      ce_n_q  <= pad_req.ce_n;
      oe_n_q  <= pad_req.oe_n;
      we_n_q  <= pad_req.we_n;
      drive_q <= pad_req.drive;
    end
  end

  assign pins = '{addr: addr_q, be_n: be_n_q, ce_n: ce_n_q, oe_n: oe_n_q, we_n: we_n_q};

  // bus released whenever not writing
  assign sram_data = drive_q ? wr_data_q : {data_width{1'bz}};

  // sample at the end of the last read cycle
  always_ff @(posedge clk) begin
    if (pad_req.capture) begin
      rd_data <= sram_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_strobe <= 1'b0;
    end else begin
      rd_strobe <= pad_req.capture;
    end
  end

endmodule

`default_nettype wire

//--- sram_resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sram_resp_fifo import sram_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        push,
  input  logic [data_width-1:0]       push_data,
  input  logic                        pop,
  output logic [data_width-1:0]       pop_data,
  output logic                        empty,
  output logic [fifo_count_width-1:0] fill_count
);

  logic [data_width-1:0]     mem [fifo_depth];
  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  logic                      full;
  logic                      do_push;
  logic                      do_pop;

  assign empty   = (fill_count == '0);
  assign full    = (fill_count == fifo_count_width'(fifo_depth));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // head of queue
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({do_push, do_pop})
        2'b10: fill_count <= fill_count + 1'b1;
        2'b01: fill_count <= fill_count - 1'b1;
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- sram_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl_top import sram_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  sram_cmd_t             cmd,
  output logic                  cmd_ready,
  output logic                  rsp_valid,
  output logic [data_width-1:0] rsp_data,
  input  logic                  rsp_ready,
  output sram_pins_t            pins,
  inout  wire  [data_width-1:0] sram_data
);

  logic                        timer_start;
  logic                        timer_last;
  pad_ctrl_t                   pad_req;
  logic                        rd_strobe;
  logic [data_width-1:0]       rd_data;
  logic [fifo_count_width-1:0] fill_count;
  logic                        fifo_empty;

  sram_access_fsm sram_access_fsm_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .timer_last (timer_last),
    .fill_count (fill_count),
    .cmd_ready  (cmd_ready),
    .timer_start(timer_start),
    .pad_req    (pad_req)
  );

  // busy is only needed inside the timer
  sram_wait_timer sram_wait_timer_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .start(timer_start),
    .busy (),
    .last (timer_last)
  );

  sram_pad_io sram_pad_io_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .pad_req  (pad_req),
    .pins     (pins),
    .rd_strobe(rd_strobe),
    .rd_data  (rd_data),
    .sram_data(sram_data)
  );

  sram_resp_fifo sram_resp_fifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (rd_strobe),
    .push_data (rd_data),
    .pop       (rsp_valid && rsp_ready),
    .pop_data  (rsp_data),
    .empty     (fifo_empty),
    .fill_count(fill_count)
  );

  assign rsp_valid = !fifo_empty;

endmodule

`default_nettype wire

//--- tb_async_sram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_async_sram import sram_pkg::*; (
  input  sram_pins_t            pins,
  inout  wire  [data_width-1:0] data
);

  logic [data_width-1:0] mem [2**addr_width];
  logic [addr_width-1:0] wr_addr;
  logic [data_width-1:0] wr_data;
  logic [strb_width-1:0] wr_be_n;
  logic                  we_n;
  logic                  rd_en;

  assign we_n = pins.we_n;
  assign rd_en = !pins.ce_n && !pins.oe_n && pins.we_n;

  // each enabled lane drives its byte while output enabled
  for (genvar i = 0; i < strb_width; i++) begin : rd_lane
    assign data[8*i +: 8] = (rd_en && !pins.be_n[i]) ? mem[pins.addr][8*i +: 8] : 8'hzz;
  end

  // address, data and lanes follow the pins during the write pulse
  always_latch begin
    if (!pins.ce_n && !pins.we_n) begin
      wr_addr <= pins.addr;
      wr_data <= data;
      wr_be_n <= pins.be_n;
    end
  end

  // commit on the trailing edge of we_n, lane by lane
  always @(posedge we_n) begin
    for (int i = 0; i < strb_width; i++) begin
      if (!wr_be_n[i]) begin
        mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- sram_ctrl_properties.sv
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl_properties import sram_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input sram_pins_t            pins,
  input logic                  drive,
  input logic                  cmd_ready,
  input logic                  rsp_valid,
  input logic                  rsp_ready,
  input logic [data_width-1:0] rsp_data
);

  oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    pins.oe_n || pins.we_n)
    else $error("oe_n and we_n are low together");

  // controller only drives the bus with the chip outputs off
  drive_only_oe_high: assert property (@(posedge clk) disable iff (!rst_n)
    drive |-> pins.oe_n)
    else $error("data bus driven while oe_n is low");

  we_pulse_width: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(pins.we_n) |-> ##access_cycles $rose(pins.we_n))
    else $error("we_n low pulse has the wrong length");

  rsp_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> $stable(rsp_data))
    else $error("rsp_data changed while stalled");

  no_accept_mid_access: assert property (@(posedge clk) disable iff (!rst_n)
    !pins.ce_n |-> !cmd_ready)
    else $error("cmd_ready high during an access");

endmodule

bind sram_ctrl_top sram_ctrl_properties sram_ctrl_properties_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .pins     (pins),
  .drive    (sram_pad_io_inst.drive_q),
  .cmd_ready(cmd_ready),
  .rsp_valid(rsp_valid),
  .rsp_ready(rsp_ready),
  .rsp_data (rsp_data)
);

`default_nettype wire

//--- tb_sram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_ctrl import sram_pkg::*; ();

  logic                  clk;
  logic                  rst_n;
  logic                  cmd_valid;
  sram_cmd_t             cmd;
  logic                  cmd_ready;
  logic                  rsp_valid;
  logic [data_width-1:0] rsp_data;
  logic                  rsp_ready;
  sram_pins_t            pins;
  wire  [data_width-1:0] sram_data;

  // parsed test lines
  logic [7:0]            op_list   [$];
  logic [addr_width-1:0] addr_list [$];
  logic [data_width-1:0] data_list [$];
  logic [strb_width-1:0] strb_list [$];
  int                    test_count;
  logic                  loaded;

  // expected memory contents and reads still owed
  logic [data_width-1:0] image   [2**addr_width];
  logic [strb_width-1:0] written [2**addr_width];
  logic [data_width-1:0] exp_q   [$];
  logic                  blocked;
  integer                seed;

  always #50 clk = ~clk;

  sram_ctrl_top sram_ctrl_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd      (cmd),
    .cmd_ready(cmd_ready),
    .rsp_valid(rsp_valid),
    .rsp_data (rsp_data),
    .rsp_ready(rsp_ready),
    .pins     (pins),
    .sram_data(sram_data)
  );

  tb_async_sram tb_async_sram_inst (
    .pins(pins),
    .data(sram_data)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("[ERROR] %0t: %s is 0x%0h, expected 0x%0h",
                         $time, name, actual, expected));
    end
  endtask

  // next falling edge, then pick rsp_ready and check the word it will pop
  task automatic tick();
    logic [31:0]           rnd;
    logic [data_width-1:0] expected;
    @(negedge clk);
    rnd = $random(seed);
    rsp_ready = !blocked && (rnd[1:0] != 2'b00);
    if (rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        stop_run("response arrived with no read outstanding");
      end else begin
        expected = exp_q.pop_front();
        check_value("rsp_data", 32'(rsp_data), 32'(expected));
      end
    end
  endtask

  task automatic load_tests();
    int                    fd;
    int                    fields;
    string                 line;
    logic [7:0]            op;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    fd = $fopen("sram_tests.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open sram_tests.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%c %h %h %b", op, addr, data, strb);
          if (fields != 4) begin
            stop_run({"malformed line in sram_tests.txt: ", line});
          end else begin
            op_list.push_back(op);
            addr_list.push_back(addr);
            data_list.push_back(data);
            strb_list.push_back(strb);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send(input logic [7:0] op, input logic [addr_width-1:0] addr,
                      input logic [data_width-1:0] data, input logic [strb_width-1:0] strb);
    int waited;
    waited = 0;
    if (op != "B") begin
      blocked = 1'b0;
    end else if (!blocked) begin
      // start the held section with an empty response path
      cmd_valid = 1'b0;
      while (exp_q.size() != 0) begin
        tick();
      end
      blocked = 1'b1;
    end
    cmd_valid = 1'b1;
    cmd = '{addr: addr, wr_en: (op == "W"), wr_data: data, wr_strb: strb};
    if (blocked && exp_q.size() >= fifo_depth) begin
      // depth-1 in the FIFO plus one in flight, so no more room
      repeat (2 * (access_cycles + 1)) begin
        check_value("cmd_ready", 32'(cmd_ready), 32'd0);
        tick();
      end
      blocked = 1'b0;
    end
    while (!cmd_ready && !(blocked && waited > access_cycles)) begin
      tick();
      waited++;
    end
    check_value("cmd_ready", 32'(cmd_ready), 32'd1);
    // accepted at the coming rising edge
    if (op == "W") begin
      for (int i = 0; i < strb_width; i++) begin
        if (strb[i]) begin
          image[addr][8*i +: 8] = data[8*i +: 8];
          written[addr][i] = 1'b1;
        end
      end
    end else if (written[addr] != '1) begin
      stop_run($sformatf("test line reads address 0x%0h before it was written", addr));
    end else begin
      exp_q.push_back(image[addr]);
    end
    tick();
    cmd_valid = 1'b0;
  endtask

  // watchdog sized from the number of test lines
  initial begin
    wait (loaded);
    repeat (test_count * 40 + 200) @(posedge clk);
    stop_run("timeout: the test sequence did not finish in time");
  end

  initial begin
    int waited;
    clk = 1'b0;
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    rsp_ready = 1'b0;
    blocked = 1'b0;
    loaded = 1'b0;
    seed = 32'h33a4;
    foreach (written[i]) begin
      written[i] = '0;
    end
    load_tests();
    test_count = op_list.size();
    loaded = 1'b1;
    repeat (5) begin
      tick();
      check_value("{ce_n,oe_n,we_n}", 32'({pins.ce_n, pins.oe_n, pins.we_n}), 32'b111);
      check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    end
    rst_n = 1'b1;
    tick();
    check_value("{ce_n,oe_n,we_n}", 32'({pins.ce_n, pins.oe_n, pins.we_n}), 32'b111);
    check_value("cmd_ready", 32'(cmd_ready), 32'd1);
    for (int i = 0; i < test_count; i++) begin
      send(op_list[i], addr_list[i], data_list[i], strb_list[i]);
    end
    blocked = 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < 200) begin
      tick();
      waited++;
    end
    repeat (access_cycles + 2) tick();
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    if (exp_q.size() == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_run("read responses still missing at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- sram_tests.txt
# op addr data strb: op W write, R read, B read with the response port held back
# addr and data in hex, strb in binary with bit 1 for the high byte
W 000 1234 11
R 000 0000 00
W 3ff a5c3 11
W 3ff 00ff 01
R 3ff 0000 00
W 3ff 7e00 10
R 3ff 0000 00
W 155 beef 11
W 2aa cafe 11
W 155 0012 01
R 155 0000 00
R 2aa 0000 00
W 001 0101 11
W 002 0202 11
W 003 0303 11
R 001 0000 00
R 002 0000 00
R 003 0000 00
R 3ff 0000 00
R 000 0000 00
B 000 0000 00
B 001 0000 00
B 002 0000 00
B 003 0000 00
B 155 0000 00
R 2aa 0000 00
W 000 ff00 10
R 000 0000 00

//--- sim.f
sram_pkg.sv
sram_wait_timer.sv
sram_access_fsm.sv
sram_pad_io.sv
sram_resp_fifo.sv
sram_ctrl_top.sv
tb_async_sram.sv
sram_ctrl_properties.sv
tb_sram_ctrl.sv

//--- Makefile
# Verilator build and run for the SRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_ctrl
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat sim.f)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): sim.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f

# exit status of the simulator is the test result
run: $(SIM) sram_tests.txt
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
